// ==== src/axi_defs_pkg.sv ====
/* AXI field widths and codes */
package axi_defs_pkg;

	// channel field widths
	localparam int addr_w  = 32;
	localparam int data_w  = 32;
	localparam int strb_w  = 4;  // one bit per data byte
	localparam int id_w    = 4;
	localparam int len_w   = 8;  // beats minus one
	localparam int size_w  = 3;  // log2 of bytes per beat
	localparam int burst_w = 2;
	localparam int resp_w  = 2;

	// burst types, WRAP and reserved are not served
	localparam logic [burst_w-1:0] burst_fixed = 2'd0;
	localparam logic [burst_w-1:0] burst_incr  = 2'd1;

	localparam logic [resp_w-1:0] resp_okay = 2'd0;  // only response ever sent

	// address queue sizing
	localparam int queue_depth = 4;
	localparam int queue_ptr_w = 2;

endpackage

// ==== src/mem_map_pkg.sv ====
/* memory map */
package mem_map_pkg;

	// word addressed RAM window
	localparam logic [axi_defs_pkg::addr_w-1:0] ram_base = 32'h8000_0000;
	localparam int ram_words   = 256;
	localparam int ram_index_w = 8;  // log2 of ram_words

	// machine timer, read only
	localparam logic [axi_defs_pkg::addr_w-1:0] mtime_lo_addr = 32'ha000_0048;
	localparam logic [axi_defs_pkg::addr_w-1:0] mtime_hi_addr = 32'ha000_004c;

endpackage

// ==== src/axi_addr_queue.sv ====
`timescale 1ns/1ps
/* address request queue */
module axi_addr_queue (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               in_valid,
	output logic                               in_ready,
	input  logic [axi_defs_pkg::addr_w-1:0]    in_addr,
	input  logic [axi_defs_pkg::id_w-1:0]      in_id,
	input  logic [axi_defs_pkg::len_w-1:0]     in_len,
	input  logic [axi_defs_pkg::size_w-1:0]    in_size,
	input  logic [axi_defs_pkg::burst_w-1:0]   in_burst,
	output logic                               head_valid,
	output logic [axi_defs_pkg::addr_w-1:0]    head_addr,
	output logic [axi_defs_pkg::id_w-1:0]      head_id,
	output logic [axi_defs_pkg::len_w-1:0]     head_len,
	output logic [axi_defs_pkg::size_w-1:0]    head_size,
	output logic [axi_defs_pkg::burst_w-1:0]   head_burst,
	input  logic                               pop
);
	import axi_defs_pkg::*;

	logic [addr_w-1:0]  addr_q  [queue_depth];
	logic [id_w-1:0]    id_q    [queue_depth];
	logic [len_w-1:0]   len_q   [queue_depth];
	logic [size_w-1:0]  size_q  [queue_depth];
	logic [burst_w-1:0] burst_q [queue_depth];
	logic [queue_ptr_w-1:0] head_ptr;
	logic [queue_ptr_w-1:0] tail_ptr;  // next free slot
	logic [queue_ptr_w:0]   count;     // needs one extra bit to tell full from empty
	logic push;
	logic take;

	assign in_ready   = (count != (queue_ptr_w+1)'(queue_depth));  // back-pressure only when full
	assign head_valid = (count != '0);
	assign push = in_valid && in_ready;
	assign take = pop && head_valid;

	// oldest entry straight from the array
	assign head_addr  = addr_q[head_ptr];
	assign head_id    = id_q[head_ptr];
	assign head_len   = len_q[head_ptr];
	assign head_size  = size_q[head_ptr];
	assign head_burst = burst_q[head_ptr];

	always_ff @(posedge clock) begin
		if (reset) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count    <= '0;
		end else begin
			if (push)
				tail_ptr <= tail_ptr + 1'b1;  // wraps on its own at depth 4
			if (take)
				head_ptr <= head_ptr + 1'b1;
			case ({push, take})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

	// payload slots
	always_ff @(posedge clock) begin
		if (push) begin
			addr_q[tail_ptr]  <= in_addr;
			id_q[tail_ptr]    <= in_id;
			len_q[tail_ptr]   <= in_len;
			size_q[tail_ptr]  <= in_size;
			burst_q[tail_ptr] <= in_burst;
		end
	end

endmodule

// ==== src/axi_read_engine.sv ====
`timescale 1ns/1ps
/* read burst engine */
module axi_read_engine (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               head_valid,
	input  logic [axi_defs_pkg::addr_w-1:0]    head_addr,
	input  logic [axi_defs_pkg::id_w-1:0]      head_id,
	input  logic [axi_defs_pkg::len_w-1:0]     head_len,
	input  logic [axi_defs_pkg::size_w-1:0]    head_size,
	input  logic [axi_defs_pkg::burst_w-1:0]   head_burst,
	output logic                               pop,
	output logic                               rd_req,
	output logic [axi_defs_pkg::addr_w-1:0]    rd_addr,
	input  logic                               rd_gnt,
	input  logic [axi_defs_pkg::data_w-1:0]    rd_data,
	output logic [axi_defs_pkg::data_w-1:0]    rdata,
	output logic [axi_defs_pkg::id_w-1:0]      rid,
	output logic [axi_defs_pkg::resp_w-1:0]    rresp,
	output logic                               rlast,
	output logic                               rvalid,
	input  logic                               rready
);
	import axi_defs_pkg::*;

	typedef enum logic [1:0] {st_req, st_wait, st_show} state_t;

	state_t           state;
	logic [len_w-1:0] beat;  // beats already handed out
	logic             supported;
	logic             last_beat;
	logic             skip;

	assign supported = (head_burst == burst_fixed) || (head_burst == burst_incr);
	assign skip      = (state == st_req) && head_valid && !supported;  // WRAP etc read zero

	// FIXED stays on the start address, INCR steps by the beat size
	assign rd_addr = (head_burst == burst_incr) ?
		head_addr + ({{(addr_w-len_w){1'b0}}, beat} << head_size) : head_addr;
	assign rd_req  = (state == st_req) && head_valid && supported;

	assign last_beat = (beat == head_len);
	assign rvalid    = (state == st_show);
	assign rlast     = rvalid && last_beat;
	assign rid       = head_id;  // head stays put until the last beat pops it
	assign rresp     = resp_okay;
	assign pop       = rvalid && rready && last_beat;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_req;
			beat  <= '0;
		end else begin
			case (state)
				st_req: begin
					if (skip)
						state <= st_show;
					else if (rd_gnt)
						state <= st_wait;  // store answers next cycle
				end
				st_wait: state <= st_show;
				st_show: begin
					if (rready) begin
						state <= st_req;
						beat  <= last_beat ? '0 : beat + 1'b1;
					end
				end
				default: state <= st_req;
			endcase
		end
	end

	// data held steady while the master stalls
	always_ff @(posedge clock) begin
		if (state == st_wait)
			rdata <= rd_data;
		else if (skip)
			rdata <= '0;
	end

endmodule

// ==== src/axi_write_engine.sv ====
`timescale 1ns/1ps
/* write burst engine */
module axi_write_engine (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               head_valid,
	input  logic [axi_defs_pkg::addr_w-1:0]    head_addr,
	input  logic [axi_defs_pkg::id_w-1:0]      head_id,
	input  logic [axi_defs_pkg::len_w-1:0]     head_len,
	input  logic [axi_defs_pkg::size_w-1:0]    head_size,
	input  logic [axi_defs_pkg::burst_w-1:0]   head_burst,
	output logic                               pop,
	input  logic [axi_defs_pkg::data_w-1:0]    wdata,
	input  logic [axi_defs_pkg::strb_w-1:0]    wstrb,
	input  logic                               wlast,
	input  logic                               wvalid,
	output logic                               wready,
	output logic                               wr_req,
	output logic [axi_defs_pkg::addr_w-1:0]    wr_addr,
	output logic [axi_defs_pkg::data_w-1:0]    wr_data,
	output logic [axi_defs_pkg::strb_w-1:0]    wr_strb,
	input  logic                               wr_gnt,
	output logic [axi_defs_pkg::id_w-1:0]      bid,
	output logic [axi_defs_pkg::resp_w-1:0]    bresp,
	output logic                               bvalid,
	input  logic                               bready
);
	import axi_defs_pkg::*;

	logic             b_pending;  // response owed for the head burst
	logic [len_w-1:0] beat;
	logic             supported;
	logic             last_beat;
	logic             w_fire;

	assign supported = (head_burst == burst_fixed) || (head_burst == burst_incr);

	// no W beat taken while B is still out
	assign wr_req  = head_valid && wvalid && !b_pending;
	assign wr_addr = (head_burst == burst_incr) ?
		head_addr + ({{(addr_w-len_w){1'b0}}, beat} << head_size) : head_addr;
	assign wr_data = wdata;
	assign wr_strb = supported ? wstrb : '0;  // unsupported bursts write nothing
	assign wready  = wr_gnt;  // beat lands in storage this cycle
	assign w_fire  = wvalid && wready;

	// a master wlast also closes a short burst
	assign last_beat = (beat == head_len) || wlast;

	assign bvalid = b_pending;
	assign bid    = head_id;
	assign bresp  = resp_okay;
	assign pop    = bvalid && bready;

	always_ff @(posedge clock) begin
		if (reset) begin
			b_pending <= 1'b0;
			beat      <= '0;
		end else begin
			if (w_fire) begin
				if (last_beat) begin
					beat      <= '0;
					b_pending <= 1'b1;  // bvalid one cycle after last beat
				end else begin
					beat <= beat + 1'b1;
				end
			end
			if (pop)
				b_pending <= 1'b0;
		end
	end

endmodule

// ==== src/storage_arbiter.sv ====
`timescale 1ns/1ps
/* storage port arbiter */
module storage_arbiter (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               rd_req,
	input  logic [axi_defs_pkg::addr_w-1:0]    rd_addr,
	output logic                               rd_gnt,
	input  logic                               wr_req,
	input  logic [axi_defs_pkg::addr_w-1:0]    wr_addr,
	input  logic [axi_defs_pkg::data_w-1:0]    wr_data,
	input  logic [axi_defs_pkg::strb_w-1:0]    wr_strb,
	output logic                               wr_gnt,
	output logic                               st_we,
	output logic [axi_defs_pkg::addr_w-1:0]    st_addr,
	output logic [axi_defs_pkg::data_w-1:0]    st_wdata,
	output logic [axi_defs_pkg::strb_w-1:0]    st_strb,
	output logic                               st_en
);
	import axi_defs_pkg::*;

	logic last_wr;  // write side was served last

	// on a tie the side not served last wins
	assign rd_gnt = rd_req && (!wr_req || last_wr);
	assign wr_gnt = wr_req && !rd_gnt;

	// steer the winner onto the port
	assign st_en    = rd_gnt || wr_gnt;
	assign st_we    = wr_gnt;
	assign st_addr  = wr_gnt ? wr_addr : rd_addr;
	assign st_wdata = wr_data;
	assign st_strb  = wr_gnt ? wr_strb : {strb_w{1'b0}};

	always_ff @(posedge clock) begin
		if (reset)
			last_wr <= 1'b0;
		else if (rd_gnt)
			last_wr <= 1'b0;
		else if (wr_gnt)
			last_wr <= 1'b1;
	end

endmodule

// ==== src/word_store.sv ====
`timescale 1ns/1ps
/* RAM and machine timer */
module word_store (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               st_en,
	input  logic                               st_we,
	input  logic [axi_defs_pkg::addr_w-1:0]    st_addr,
	input  logic [axi_defs_pkg::data_w-1:0]    st_wdata,
	input  logic [axi_defs_pkg::strb_w-1:0]    st_strb,
	output logic [axi_defs_pkg::data_w-1:0]    st_rdata
);
	import axi_defs_pkg::*;
	import mem_map_pkg::*;

	logic [data_w-1:0]      ram [ram_words];
	logic [63:0]            mtime;
	logic [addr_w-1:0]      offset;  // byte offset into the RAM window
	logic [ram_index_w-1:0] index;
	logic                   in_ram;
	logic                   hit_lo;
	logic                   hit_hi;

	assign offset = st_addr - ram_base;
	assign in_ram = (offset[addr_w-1:ram_index_w+2] == '0);  // wraps below base too
	assign index  = offset[ram_index_w+1:2];                 // byte lanes ignored
	assign hit_lo = (st_addr[addr_w-1:2] == mtime_lo_addr[addr_w-1:2]);
	assign hit_hi = (st_addr[addr_w-1:2] == mtime_hi_addr[addr_w-1:2]);

	// free running timer
	always_ff @(posedge clock) begin
		if (reset)
			mtime <= '0;
		else
			mtime <= mtime + 64'd1;
	end

	// byte strobed writes, timer and unmapped space ignore them
	always_ff @(posedge clock) begin
		if (st_en && st_we && in_ram) begin
			for (int b = 0; b < strb_w; b++) begin
				if (st_strb[b])
					ram[index][8*b +: 8] <= st_wdata[8*b +: 8];
			end
		end
	end

	// read data out one cycle after the grant
	always_ff @(posedge clock) begin
		if (st_en && !st_we) begin
			if (in_ram)
				st_rdata <= ram[index];
			else if (hit_lo)
				st_rdata <= mtime[31:0];
			else if (hit_hi)
				st_rdata <= mtime[63:32];
			else
				st_rdata <= '0;  // unmapped reads zero
		end
	end

endmodule

// ==== src/axi_mem_top.sv ====
`timescale 1ns/1ps
/* AXI4 memory slave */
module axi_mem_top (
	input  logic                               clock,
	input  logic                               reset,
	input  logic [axi_defs_pkg::addr_w-1:0]    araddr,
	input  logic                               arvalid,
	output logic                               arready,
	input  logic [axi_defs_pkg::id_w-1:0]      arid,
	input  logic [axi_defs_pkg::len_w-1:0]     arlen,
	input  logic [axi_defs_pkg::size_w-1:0]    arsize,
	input  logic [axi_defs_pkg::burst_w-1:0]   arburst,
	output logic [axi_defs_pkg::data_w-1:0]    rdata,
	output logic [axi_defs_pkg::resp_w-1:0]    rresp,
	output logic                               rvalid,
	input  logic                               rready,
	output logic                               rlast,
	output logic [axi_defs_pkg::id_w-1:0]      rid,
	input  logic [axi_defs_pkg::addr_w-1:0]    awaddr,
	input  logic                               awvalid,
	output logic                               awready,
	input  logic [axi_defs_pkg::id_w-1:0]      awid,
	input  logic [axi_defs_pkg::len_w-1:0]     awlen,
	input  logic [axi_defs_pkg::size_w-1:0]    awsize,
	input  logic [axi_defs_pkg::burst_w-1:0]   awburst,
	input  logic [axi_defs_pkg::data_w-1:0]    wdata,
	input  logic [axi_defs_pkg::strb_w-1:0]    wstrb,
	input  logic                               wvalid,
	output logic                               wready,
	input  logic                               wlast,
	output logic [axi_defs_pkg::resp_w-1:0]    bresp,
	output logic                               bvalid,
	input  logic                               bready,
	output logic [axi_defs_pkg::id_w-1:0]      bid
);
	import axi_defs_pkg::*;

	// read queue head
	logic               ar_head_valid;
	logic [addr_w-1:0]  ar_head_addr;
	logic [id_w-1:0]    ar_head_id;
	logic [len_w-1:0]   ar_head_len;
	logic [size_w-1:0]  ar_head_size;
	logic [burst_w-1:0] ar_head_burst;
	logic               ar_pop;
	// write queue head
	logic               aw_head_valid;
	logic [addr_w-1:0]  aw_head_addr;
	logic [id_w-1:0]    aw_head_id;
	logic [len_w-1:0]   aw_head_len;
	logic [size_w-1:0]  aw_head_size;
	logic [burst_w-1:0] aw_head_burst;
	logic               aw_pop;
	// engine side of the arbiter
	logic               rd_req;
	logic [addr_w-1:0]  rd_addr;
	logic               rd_gnt;
	logic               wr_req;
	logic [addr_w-1:0]  wr_addr;
	logic [data_w-1:0]  wr_data;
	logic [strb_w-1:0]  wr_strb;
	logic               wr_gnt;
	// single storage port
	logic               st_en;
	logic               st_we;
	logic [addr_w-1:0]  st_addr;
	logic [data_w-1:0]  st_wdata;
	logic [strb_w-1:0]  st_strb;
	logic [data_w-1:0]  st_rdata;

	axi_addr_queue u_ar_queue (
		.clock(clock), .reset(reset),
		.in_valid(arvalid), .in_ready(arready),
		.in_addr(araddr), .in_id(arid), .in_len(arlen), .in_size(arsize), .in_burst(arburst),
		.head_valid(ar_head_valid), .head_addr(ar_head_addr), .head_id(ar_head_id),
		.head_len(ar_head_len), .head_size(ar_head_size), .head_burst(ar_head_burst),
		.pop(ar_pop)
	);

	axi_addr_queue u_aw_queue (
		.clock(clock), .reset(reset),
		.in_valid(awvalid), .in_ready(awready),
		.in_addr(awaddr), .in_id(awid), .in_len(awlen), .in_size(awsize), .in_burst(awburst),
		.head_valid(aw_head_valid), .head_addr(aw_head_addr), .head_id(aw_head_id),
		.head_len(aw_head_len), .head_size(aw_head_size), .head_burst(aw_head_burst),
		.pop(aw_pop)
	);

	axi_read_engine u_read_engine (
		.clock(clock), .reset(reset),
		.head_valid(ar_head_valid), .head_addr(ar_head_addr), .head_id(ar_head_id),
		.head_len(ar_head_len), .head_size(ar_head_size), .head_burst(ar_head_burst),
		.pop(ar_pop),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_gnt(rd_gnt), .rd_data(st_rdata),
		.rdata(rdata), .rid(rid), .rresp(rresp), .rlast(rlast),
		.rvalid(rvalid), .rready(rready)
	);

	axi_write_engine u_write_engine (
		.clock(clock), .reset(reset),
		.head_valid(aw_head_valid), .head_addr(aw_head_addr), .head_id(aw_head_id),
		.head_len(aw_head_len), .head_size(aw_head_size), .head_burst(aw_head_burst),
		.pop(aw_pop),
		.wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb),
		.wr_gnt(wr_gnt),
		.bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

	storage_arbiter u_arbiter (
		.clock(clock), .reset(reset),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_gnt(rd_gnt),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb),
		.wr_gnt(wr_gnt),
		.st_we(st_we), .st_addr(st_addr), .st_wdata(st_wdata), .st_strb(st_strb),
		.st_en(st_en)
	);

	word_store u_store (
		.clock(clock), .reset(reset),
		.st_en(st_en), .st_we(st_we), .st_addr(st_addr),
		.st_wdata(st_wdata), .st_strb(st_strb), .st_rdata(st_rdata)
	);

endmodule

// ==== test/axi_mem_assertions.sv ====
`timescale 1ns/1ps
/* AXI slave protocol checks */
module axi_mem_assertions (
	input logic                             clock,
	input logic                             reset,
	input logic                             rvalid,
	input logic                             rready,
	input logic [axi_defs_pkg::data_w-1:0]  rdata,
	input logic [axi_defs_pkg::id_w-1:0]    rid,
	input logic                             rlast,
	input logic                             bvalid,
	input logic                             wvalid,
	input logic                             wready,
	input logic                             wlast
);
	int fail_count = 0;  // read back by the testbench

	// both response channels quiet coming out of reset
	reset_quiet: assert property (@(posedge clock) reset |=> !rvalid && !bvalid)
		else begin
			fail_count++;
			$error("rvalid or bvalid high right after reset");
		end

	// R payload frozen while the master stalls
	r_stable: assert property (@(posedge clock) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid) && $stable(rlast))
		else begin
			fail_count++;
			$error("R channel changed while waiting for rready");
		end

	b_after_last: assert property (@(posedge clock) disable iff (reset)
		wvalid && wready && wlast |=> bvalid)  // exactly one cycle later
		else begin
			fail_count++;
			$error("bvalid did not rise one cycle after the last W beat");
		end

	b_rise_cause: assert property (@(posedge clock) disable iff (reset)
		$rose(bvalid) |-> $past(wvalid && wready && wlast))
		else begin
			fail_count++;
			$error("bvalid rose without a last W beat on the cycle before");
		end

	no_w_during_b: assert property (@(posedge clock) disable iff (reset) !(wready && bvalid))
		else begin
			fail_count++;
			$error("wready high while a B response is pending");
		end

endmodule

bind axi_mem_top axi_mem_assertions u_assertions (.*);

// ==== test/axi_mem_tb.sv ====
`timescale 1ns/1ps
/* AXI memory slave testbench */
module axi_mem_tb;
	import axi_defs_pkg::*;
	import mem_map_pkg::*;

	// six tests of up to ~40 beats, doubled for stalls plus a wide margin
	localparam int max_cycles = 3000;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic [addr_w-1:0] araddr, awaddr;
	logic arvalid, awvalid, rready, wvalid, wlast, bready;
	logic [id_w-1:0] arid, awid;
	logic [len_w-1:0] arlen, awlen;
	logic [size_w-1:0] arsize, awsize;
	logic [burst_w-1:0] arburst, awburst;
	logic [data_w-1:0] wdata;
	logic [strb_w-1:0] wstrb;
	wire arready, awready, rvalid, rlast, wready, bvalid;
	wire [data_w-1:0] rdata;
	wire [resp_w-1:0] rresp, bresp;
	wire [id_w-1:0] rid, bid;

	logic [data_w-1:0] ref_mem [ram_words];  // reference copy of the RAM window
	logic [data_w-1:0] wbuf_data [16];        // beats of the next write burst
	logic [strb_w-1:0] wbuf_strb [16];
	logic [data_w-1:0] got_data [16];         // beats of the last read burst
	logic [data_w-1:0] first_time;
	integer seed = 30692;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int test_count = 0;
	int mark = 0;

	axi_mem_top u_axi_mem_top (.*);

	always #50 clock = ~clock;

	// watchdog
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles == max_cycles) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic int total_errors();
		return errors + u_axi_mem_top.u_assertions.fail_count;
	endfunction

	// FIXED keeps the start address while INCR steps one word per beat
	function automatic logic [addr_w-1:0] beat_addr(input logic [addr_w-1:0] start,
			input int n, input logic [burst_w-1:0] burst);
		return (burst == burst_incr) ? start + (n << 2) : start;
	endfunction

	function automatic int ram_index(input logic [addr_w-1:0] addr);
		return ((addr - ram_base) >> 2) & (ram_words - 1);
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("test %0d %s: %s", test_count, name,
			(total_errors() == mark) ? "ok" : "errors");
		mark = total_errors();
	endtask

	task automatic issue_ar(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
			input logic [len_w-1:0] len, input logic [burst_w-1:0] burst);
		arid <= id;
		araddr <= addr;
		arlen <= len;
		arsize <= 3'd2;
		arburst <= burst;
		arvalid <= 1'b1;
		@(posedge clock);
		while (!arready)
			@(posedge clock);
		arvalid <= 1'b0;
	endtask

	// takes one R burst under random rready stalls
	task automatic collect_r(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
			input logic [len_w-1:0] len, input logic [burst_w-1:0] burst, input bit use_model);
		int beat;
		beat = 0;
		rready <= ($random(seed) & 3) != 0;
		while (beat <= len) begin
			@(posedge clock);
			if (rvalid && rready) begin
				if (use_model)
					check_value("rdata", ref_mem[ram_index(beat_addr(addr, beat, burst))], rdata);
				got_data[beat] = rdata;
				check_value("rid", id, rid);
				check_value("rlast", beat == len, rlast);
				check_value("rresp", resp_okay, rresp);
				beat++;
			end
			rready <= (beat <= len) && (($random(seed) & 3) != 0);
		end
	endtask

	// AW handshake then the W beats from wbuf and finally the B response
	task automatic write_burst(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
			input logic [len_w-1:0] len, input logic [burst_w-1:0] burst);
		int n;
		int idx;
		bit done;
		awid <= id;
		awaddr <= addr;
		awlen <= len;
		awsize <= 3'd2;
		awburst <= burst;
		awvalid <= 1'b1;
		@(posedge clock);
		while (!awready)
			@(posedge clock);
		awvalid <= 1'b0;
		for (n = 0; n <= len; n++) begin
			wdata <= wbuf_data[n];
			wstrb <= wbuf_strb[n];
			wlast <= (n == len);
			wvalid <= 1'b1;
			@(posedge clock);
			while (!wready)
				@(posedge clock);
			idx = ram_index(beat_addr(addr, n, burst));  // mirror the landed beat
			for (int b = 0; b < strb_w; b++)
				if (wbuf_strb[n][b])
					ref_mem[idx][8*b +: 8] = wbuf_data[n][8*b +: 8];
		end
		// master keeps W offered while B is pending
		wlast <= 1'b0;
		done = 0;
		bready <= ($random(seed) & 1) != 0;
		while (!done) begin
			@(posedge clock);
			if (bvalid && bready) begin
				check_value("bid", id, bid);
				check_value("bresp", resp_okay, bresp);
				done = 1;
			end
			bready <= !done && (($random(seed) & 1) != 0);
		end
		wvalid <= 1'b0;
	endtask

	initial begin
		arvalid = 1'b0;
		araddr = '0;
		arid = '0;
		arlen = '0;
		arsize = '0;
		arburst = '0;
		awvalid = 1'b0;
		awaddr = '0;
		awid = '0;
		awlen = '0;
		awsize = '0;
		awburst = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wlast = 1'b0;
		rready = 1'b0;
		bready = 1'b0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;

		@(posedge clock);
		check_value("rvalid", 0, rvalid);
		check_value("bvalid", 0, bvalid);
		check_value("arready", 1, arready);
		check_value("awready", 1, awready);
		end_test("reset state");

		for (int n = 0; n < 8; n++) begin
			wbuf_data[n] = $random(seed);
			wbuf_strb[n] = 4'hf;
		end
		write_burst(4'd2, 32'h8000_0100, 8'd7, burst_incr);
		issue_ar(4'd4, 32'h8000_0100, 8'd7, burst_incr);
		collect_r(4'd4, 32'h8000_0100, 8'd7, burst_incr, 1'b1);
		end_test("incr write and read");

		// each lane gets a byte and lane 0 is overwritten by the last beat
		wbuf_data[0] = 32'h1122_3344;
		wbuf_strb[0] = 4'b0011;
		wbuf_data[1] = 32'h5566_7788;
		wbuf_strb[1] = 4'b0100;
		wbuf_data[2] = 32'h99aa_bbcc;
		wbuf_strb[2] = 4'b1000;
		wbuf_data[3] = 32'hddee_ff00;
		wbuf_strb[3] = 4'b0001;
		write_burst(4'd1, 32'h8000_0040, 8'd3, burst_fixed);
		issue_ar(4'd7, 32'h8000_0040, 8'd0, burst_fixed);
		collect_r(4'd7, 32'h8000_0040, 8'd0, burst_fixed, 1'b1);
		end_test("fixed strobe merge");

		issue_ar(4'd3, 32'h8000_0100, 8'd2, burst_incr);
		issue_ar(4'd5, 32'h8000_0108, 8'd4, burst_incr);
		issue_ar(4'd9, 32'h8000_0040, 8'd0, burst_fixed);
		collect_r(4'd3, 32'h8000_0100, 8'd2, burst_incr, 1'b1);  // issue order
		collect_r(4'd5, 32'h8000_0108, 8'd4, burst_incr, 1'b1);
		collect_r(4'd9, 32'h8000_0040, 8'd0, burst_fixed, 1'b1);
		end_test("queued reads");

		issue_ar(4'd0, mtime_lo_addr, 8'd0, burst_incr);
		collect_r(4'd0, mtime_lo_addr, 8'd0, burst_incr, 1'b0);
		first_time = got_data[0];
		repeat (10) @(posedge clock);
		issue_ar(4'd0, mtime_lo_addr, 8'd0, burst_incr);
		collect_r(4'd0, mtime_lo_addr, 8'd0, burst_incr, 1'b0);
		checks++;
		assert (got_data[0] > first_time) else begin
			errors++;
			$display("machine timer did not advance between two reads");
		end
		issue_ar(4'd1, mtime_hi_addr, 8'd0, burst_incr);
		collect_r(4'd1, mtime_hi_addr, 8'd0, burst_incr, 1'b0);
		check_value("rdata", 0, got_data[0]);  // high word still zero this early
		issue_ar(4'd2, 32'h4000_0000, 8'd0, burst_incr);
		collect_r(4'd2, 32'h4000_0000, 8'd0, burst_incr, 1'b0);
		check_value("rdata", 0, got_data[0]);
		end_test("timer and unmapped");

		for (int n = 0; n < 4; n++) begin
			wbuf_data[n] = $random(seed);
			wbuf_strb[n] = 4'hf;
		end
		fork
			write_burst(4'd6, 32'h8000_0200, 8'd3, burst_incr);
			begin
				issue_ar(4'd8, 32'h8000_0100, 8'd3, burst_incr);
				collect_r(4'd8, 32'h8000_0100, 8'd3, burst_incr, 1'b1);
			end
		join
		issue_ar(4'd10, 32'h8000_0200, 8'd3, burst_incr);  // written words came through
		collect_r(4'd10, 32'h8000_0200, 8'd3, burst_incr, 1'b1);
		end_test("concurrent read and write");

		$display("summary: %0d tests, %0d checks, %0d errors",
			test_count, checks, total_errors());
		if (total_errors() == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== axi_mem_top.f ====
src/axi_defs_pkg.sv
src/mem_map_pkg.sv
src/axi_addr_queue.sv
src/axi_read_engine.sv
src/axi_write_engine.sv
src/storage_arbiter.sv
src/word_store.sv
src/axi_mem_top.sv
test/axi_mem_assertions.sv
test/axi_mem_tb.sv
